/* Makefile */
VERILATOR ?= verilator
TOP       ?= rrag_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* include/rrag_defs.svh */
`ifndef RRAG_DEFS_SVH
`define RRAG_DEFS_SVH

// Register file sizes
`define RRAG_NUM_GPR 8
`define RRAG_NUM_SEG 8

// Datapath widths
`define RRAG_DATA_W 32
`define RRAG_SEL_W 16
`define RRAG_LIM_W 20

// Instruction tag width, wraps after 128 issued micro-ops
`define RRAG_TAG_W 7

// Writeback ports per register file
`define RRAG_WB_PORTS 4

`endif

/* logic/addr_gen.sv */
`timescale 1ns/100ps
`include "rrag_defs.svh"

module addr_gen (
    input  rrag_pkg::uop_t          uop,
    input  logic [`RRAG_DATA_W-1:0] base,
    input  logic [`RRAG_DATA_W-1:0] index,
    input  logic [`RRAG_DATA_W-1:0] str,
    input  logic [`RRAG_SEL_W-1:0]  sel1,
    input  logic [`RRAG_SEL_W-1:0]  sel2,
    output logic [`RRAG_DATA_W-1:0] mem_addr1,
    output logic [`RRAG_DATA_W-1:0] mem_addr2,
    output logic [`RRAG_DATA_W-1:0] mem_addr1_end,
    output logic [`RRAG_DATA_W-1:0] mem_addr2_end
);

    localparam int PAD_W = `RRAG_DATA_W - `RRAG_SEL_W;

    logic [`RRAG_DATA_W-1:0] base_term;
    logic [`RRAG_DATA_W-1:0] index_term;
    logic [`RRAG_DATA_W-1:0] seg1_base;
    logic [`RRAG_DATA_W-1:0] seg2_base;
    logic [`RRAG_DATA_W-1:0] seg_disp;
    logic [`RRAG_DATA_W-1:0] size_m1;

    assign base_term  = uop.use_base ? base : '0;
    // Scaled index of a SIB operand
    assign index_term = uop.use_index ? (index << uop.scale) : '0;

    // Selector acts as a flat base in the upper half of the address
    assign seg1_base = {sel1, {PAD_W{1'b0}}};
    assign seg2_base = {sel2, {PAD_W{1'b0}}};
    assign seg_disp  = uop.disp + seg1_base;

    assign mem_addr1 = base_term + index_term + seg_disp;
    assign mem_addr2 = str + seg2_base;

    // Last byte touched by each access
    assign size_m1       = rrag_pkg::opsize_bytes(uop.opsize) - 1'b1;
    assign mem_addr1_end = mem_addr1 + size_m1;
    assign mem_addr2_end = mem_addr2 + size_m1;

endmodule

/* logic/gpr_file.sv */
`timescale 1ns/100ps
`include "rrag_defs.svh"

module gpr_file (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [3:0][2:0]                          rd_addr,
    input  rrag_pkg::reg_wb_t [`RRAG_WB_PORTS-1:0]   wb,
    input  logic                                     set_pending,
    input  logic [`RRAG_NUM_GPR-1:0]                 dest_mask,
    input  logic [`RRAG_TAG_W-1:0]                   new_tag,
    output logic [3:0][`RRAG_DATA_W-1:0]             rd_data,
    output logic [3:0]                               rd_pending
);

    logic [`RRAG_NUM_GPR-1:0][`RRAG_DATA_W-1:0] regs;
    logic [`RRAG_NUM_GPR-1:0]                   pending;
    logic [`RRAG_NUM_GPR-1:0][`RRAG_TAG_W-1:0]  ptag;
    logic [`RRAG_NUM_GPR-1:0]                   tag_clash;

    // Later ports override earlier ones, and a new pending mark overrides a clear
    always_ff @(posedge clk) begin
        if (reset) begin
            regs    <= '0;
            pending <= '0;
        end else begin
            for (int p = 0; p < `RRAG_WB_PORTS; p++) begin
                if (wb[p].valid) begin
                    regs[wb[p].addr] <= wb[p].data;
                    if (wb[p].tag == ptag[wb[p].addr]) begin
                        pending[wb[p].addr] <= 1'b0;
                    end
                end
            end
            if (set_pending) begin
                for (int r = 0; r < `RRAG_NUM_GPR; r++) begin
                    if (dest_mask[r]) begin
                        pending[r] <= 1'b1;
                    end
                end
            end
        end
    end

    // Writer tag of the most recent pending mark
    always_ff @(posedge clk) begin
        if (set_pending) begin
            for (int r = 0; r < `RRAG_NUM_GPR; r++) begin
                if (dest_mask[r]) begin
                    ptag[r] <= new_tag;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_data[i]    = regs[rd_addr[i]];
            rd_pending[i] = pending[rd_addr[i]];
        end
    end

    always_comb begin
        for (int r = 0; r < `RRAG_NUM_GPR; r++) begin
            tag_clash[r] = pending[r] && (ptag[r] == new_tag);
        end
    end

    // Tag space must not wrap onto a writer whose result is still outstanding
    a_no_tag_reuse: assert property (@(posedge clk) disable iff (reset)
        set_pending |-> !(|tag_clash));

endmodule

/* logic/rep_unit.sv */
`timescale 1ns/100ps
`include "rrag_defs.svh"

module rep_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    hold,
    input  logic [`RRAG_DATA_W-1:0] count,
    input  rrag_pkg::opsize_e       opsize,
    input  logic [`RRAG_DATA_W-1:0] addr1_in,
    input  logic [`RRAG_DATA_W-1:0] addr2_in,
    output logic [`RRAG_DATA_W-1:0] addr1,
    output logic [`RRAG_DATA_W-1:0] addr2,
    output logic [`RRAG_DATA_W-1:0] rep_index,
    output logic                    rep_last,
    output logic                    rep_stall
);

    rrag_pkg::rep_state_e state;

    logic [`RRAG_DATA_W-1:0] remaining;
    logic [`RRAG_DATA_W-1:0] offset;
    logic [`RRAG_DATA_W-1:0] index;
    logic [`RRAG_DATA_W-1:0] count_eff;
    logic [`RRAG_DATA_W-1:0] step;

    // A zero count still runs the string op once
    assign count_eff = (count == '0) ? `RRAG_DATA_W'(1) : count;
    assign step      = rrag_pkg::opsize_bytes(opsize);

    always_comb begin
        addr1     = addr1_in;
        addr2     = addr2_in;
        rep_index = '0;
        rep_last  = 1'b0;
        rep_stall = 1'b0;
        if (state == rrag_pkg::rep_run) begin
            addr1     = addr1_in + offset;
            addr2     = addr2_in + offset;
            rep_index = index;
            rep_last  = (remaining == `RRAG_DATA_W'(1));
            rep_stall = (remaining != `RRAG_DATA_W'(1));
        end else if (start) begin
            // Iteration 0 goes out straight from idle
            rep_last  = (count_eff == `RRAG_DATA_W'(1));
            rep_stall = (count_eff != `RRAG_DATA_W'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rrag_pkg::rep_idle;
        end else if (!hold) begin
            case (state)
                rrag_pkg::rep_idle: begin
                    if (start && count_eff != `RRAG_DATA_W'(1)) begin
                        state <= rrag_pkg::rep_run;
                    end
                end
                rrag_pkg::rep_run: begin
                    if (remaining == `RRAG_DATA_W'(1)) begin
                        state <= rrag_pkg::rep_idle;
                    end
                end
                default: state <= rrag_pkg::rep_idle;
            endcase
        end
    end

    // Loaded on leaving idle, stepped once per issued iteration
    always_ff @(posedge clk) begin
        if (!hold) begin
            if (state == rrag_pkg::rep_idle) begin
                remaining <= count_eff - 1'b1;
                offset    <= step;
                index     <= `RRAG_DATA_W'(1);
            end else begin
                remaining <= remaining - 1'b1;
                offset    <= offset + step;
                index     <= index + 1'b1;
            end
        end
    end

    // Upstream holds the rep op for the whole sequence
    a_start_in_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(start) |-> state == rrag_pkg::rep_idle);

endmodule

/* logic/rrag.sv */
`timescale 1ns/100ps
`include "rrag_defs.svh"

module rrag (
    input  logic                                   clk,
    input  logic                                   reset,
    input  rrag_pkg::uop_t                         uop,
    input  logic                                   uop_valid,
    input  rrag_pkg::reg_wb_t [`RRAG_WB_PORTS-1:0] reg_wb,
    input  rrag_pkg::seg_wb_t [`RRAG_WB_PORTS-1:0] seg_wb,
    input  logic                                   fwd_stall,
    output logic                                   stall,
    output logic                                   out_valid,
    output rrag_pkg::stage_out_t                   out
);

    logic [`RRAG_TAG_W-1:0]             tag;
    logic [3:0][2:0]                    gpr_addr;
    logic [3:0][`RRAG_DATA_W-1:0]       gpr_data;
    logic [3:0]                         gpr_pend;
    logic [1:0][2:0]                    seg_addr;
    logic [1:0][`RRAG_SEL_W-1:0]        sel;
    logic [1:0][`RRAG_LIM_W-1:0]        lim;
    logic [1:0]                         seg_pend;
    logic [`RRAG_DATA_W-1:0]            ag_addr1;
    logic [`RRAG_DATA_W-1:0]            ag_addr2;
    logic [`RRAG_DATA_W-1:0]            ag_end1;
    logic [`RRAG_DATA_W-1:0]            ag_end2;
    logic [`RRAG_DATA_W-1:0]            rep_addr1;
    logic [`RRAG_DATA_W-1:0]            rep_addr2;
    logic [`RRAG_DATA_W-1:0]            rep_off;
    logic [`RRAG_DATA_W-1:0]            rep_index;
    logic                               rep_last;
    logic                               rep_stall;
    logic                               hazard;
    logic                               set_pending;

    // Read ports in order base, index, rep count and string source
    assign gpr_addr = {uop.str_addr, uop.rep_count_addr, uop.index_addr, uop.base_addr};
    assign seg_addr = {uop.seg2_addr, uop.seg1_addr};

    assign hazard = uop_valid && ((uop.use_base && gpr_pend[0])
                               || (uop.use_index && gpr_pend[1])
                               || (uop.is_rep && gpr_pend[2])
                               || (uop.mem2_use && (gpr_pend[3] || seg_pend[1]))
                               || (uop.mem1_use && seg_pend[0]));

    assign out_valid = uop_valid && !hazard && !fwd_stall;
    assign stall     = hazard || fwd_stall || rep_stall;

    // A rep op claims its destinations only on its final iteration
    assign set_pending = out_valid && (!uop.is_rep || rep_last);

    tag_generator u_tag (.clk(clk), .reset(reset), .advance(out_valid), .tag(tag));

    gpr_file u_gpr (
        .clk(clk), .reset(reset), .rd_addr(gpr_addr), .wb(reg_wb),
        .set_pending(set_pending), .dest_mask(uop.gpr_dest), .new_tag(tag),
        .rd_data(gpr_data), .rd_pending(gpr_pend)
    );

    seg_file u_seg (
        .clk(clk), .reset(reset), .rd_addr(seg_addr), .wb(seg_wb),
        .set_pending(set_pending), .dest_mask(uop.seg_dest), .new_tag(tag),
        .selector(sel), .limit(lim), .rd_pending(seg_pend)
    );

    addr_gen u_ag (
        .uop(uop), .base(gpr_data[0]), .index(gpr_data[1]), .str(gpr_data[3]),
        .sel1(sel[0]), .sel2(sel[1]), .mem_addr1(ag_addr1), .mem_addr2(ag_addr2),
        .mem_addr1_end(ag_end1), .mem_addr2_end(ag_end2)
    );

    rep_unit u_rep (
        .clk(clk), .reset(reset), .start(uop_valid && uop.is_rep),
        .hold(fwd_stall || hazard), .count(gpr_data[2]), .opsize(uop.opsize),
        .addr1_in(ag_addr1), .addr2_in(ag_addr2), .addr1(rep_addr1), .addr2(rep_addr2),
        .rep_index(rep_index), .rep_last(rep_last), .rep_stall(rep_stall)
    );

    // Both streams step by the same amount, so one offset moves both end addresses
    assign rep_off = rep_addr1 - ag_addr1;

    always_comb begin
        out.tag           = tag;
        out.mem_addr1     = rep_addr1;
        out.mem_addr2     = rep_addr2;
        out.mem_addr1_end = ag_end1 + rep_off;
        out.mem_addr2_end = ag_end2 + rep_off;
        out.reg1          = gpr_data[0];
        out.reg2          = gpr_data[1];
        out.reg3          = gpr_data[2];
        out.reg4          = gpr_data[3];
        out.sel1          = sel[0];
        out.sel2          = sel[1];
        out.lim1          = lim[0];
        out.lim2          = lim[1];
        out.rep_index     = rep_index;
        out.rep_last      = rep_last;
        out.opsize        = uop.opsize;
    end

endmodule

/* logic/rrag_pkg.sv */
`include "rrag_defs.svh"

package rrag_pkg;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2,
        size_qword = 2'd3
    } opsize_e;

    typedef enum logic {
        rep_idle = 1'b0,
        rep_run  = 1'b1
    } rep_state_e;

    typedef struct packed {
        logic [2:0]               base_addr;
        logic [2:0]               index_addr;
        logic [2:0]               rep_count_addr;
        logic [2:0]               str_addr;
        logic [2:0]               seg1_addr;
        logic [2:0]               seg2_addr;
        opsize_e                  opsize;
        logic [`RRAG_DATA_W-1:0]  disp;
        logic [1:0]               scale;
        logic                     use_base;
        logic                     use_index;
        logic                     mem1_use;
        logic                     mem2_use;
        logic                     is_rep;
        logic [`RRAG_NUM_GPR-1:0] gpr_dest;
        logic [`RRAG_NUM_SEG-1:0] seg_dest;
    } uop_t;

    typedef struct packed {
        logic                    valid;
        logic [2:0]              addr;
        logic [`RRAG_DATA_W-1:0] data;
        logic [`RRAG_TAG_W-1:0]  tag;
    } reg_wb_t;

    typedef struct packed {
        logic                   valid;
        logic [2:0]             addr;
        logic [`RRAG_SEL_W-1:0] selector;
        logic [`RRAG_TAG_W-1:0] tag;
    } seg_wb_t;

    typedef struct packed {
        logic [`RRAG_TAG_W-1:0]  tag;
        logic [`RRAG_DATA_W-1:0] mem_addr1;
        logic [`RRAG_DATA_W-1:0] mem_addr2;
        logic [`RRAG_DATA_W-1:0] mem_addr1_end;
        logic [`RRAG_DATA_W-1:0] mem_addr2_end;
        // base, index, rep count, string source
        logic [`RRAG_DATA_W-1:0] reg1;
        logic [`RRAG_DATA_W-1:0] reg2;
        logic [`RRAG_DATA_W-1:0] reg3;
        logic [`RRAG_DATA_W-1:0] reg4;
        logic [`RRAG_SEL_W-1:0]  sel1;
        logic [`RRAG_SEL_W-1:0]  sel2;
        logic [`RRAG_LIM_W-1:0]  lim1;
        logic [`RRAG_LIM_W-1:0]  lim2;
        logic [`RRAG_DATA_W-1:0] rep_index;
        logic                    rep_last;
        opsize_e                 opsize;
    } stage_out_t;

    // Access size in bytes: 1, 2, 4 or 8
    function automatic logic [`RRAG_DATA_W-1:0] opsize_bytes(opsize_e size);
        return {{(`RRAG_DATA_W-4){1'b0}}, 4'b0001 << size};
    endfunction

endpackage

/* logic/seg_file.sv */
`timescale 1ns/100ps
`include "rrag_defs.svh"

module seg_file (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [1:0][2:0]                          rd_addr,
    input  rrag_pkg::seg_wb_t [`RRAG_WB_PORTS-1:0]   wb,
    input  logic                                     set_pending,
    input  logic [`RRAG_NUM_SEG-1:0]                 dest_mask,
    input  logic [`RRAG_TAG_W-1:0]                   new_tag,
    output logic [1:0][`RRAG_SEL_W-1:0]              selector,
    output logic [1:0][`RRAG_LIM_W-1:0]              limit,
    output logic [1:0]                               rd_pending
);

    logic [`RRAG_NUM_SEG-1:0][`RRAG_SEL_W-1:0] sels;
    logic [`RRAG_NUM_SEG-1:0][`RRAG_LIM_W-1:0] lims;
    logic [`RRAG_NUM_SEG-1:0]                  pending;
    logic [`RRAG_NUM_SEG-1:0][`RRAG_TAG_W-1:0] ptag;

    always_ff @(posedge clk) begin
        if (reset) begin
            sels    <= '0;
            pending <= '0;
        end else begin
            for (int p = 0; p < `RRAG_WB_PORTS; p++) begin
                if (wb[p].valid) begin
                    sels[wb[p].addr] <= wb[p].selector;
                    if (wb[p].tag == ptag[wb[p].addr]) begin
                        pending[wb[p].addr] <= 1'b0;
                    end
                end
            end
            if (set_pending) begin
                for (int s = 0; s < `RRAG_NUM_SEG; s++) begin
                    if (dest_mask[s]) begin
                        pending[s] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (set_pending) begin
            for (int s = 0; s < `RRAG_NUM_SEG; s++) begin
                if (dest_mask[s]) begin
                    ptag[s] <= new_tag;
                end
            end
        end
    end

    // Segment k spans 64K starting at k * 64K, fixed after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `RRAG_NUM_SEG; s++) begin
                lims[s] <= 20'h0FFFF + `RRAG_LIM_W'(s) * 20'h10000;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            selector[i]   = sels[rd_addr[i]];
            limit[i]      = lims[rd_addr[i]];
            rd_pending[i] = pending[rd_addr[i]];
        end
    end

endmodule

/* logic/tag_generator.sv */
`timescale 1ns/100ps
`include "rrag_defs.svh"

module tag_generator (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   advance,
    output logic [`RRAG_TAG_W-1:0] tag
);

    // Wraps naturally at the tag width
    always_ff @(posedge clk) begin
        if (reset) begin
            tag <= '0;
        end else if (advance) begin
            tag <= tag + 1'b1;
        end
    end

endmodule

/* project.f */
+incdir+include
logic/rrag_pkg.sv
logic/tag_generator.sv
logic/gpr_file.sv
logic/seg_file.sv
logic/addr_gen.sv
logic/rep_unit.sv
logic/rrag.sv
testbench/rrag_tb.sv

/* testbench/rrag_tb.sv */
`timescale 1ns/100ps
`include "rrag_defs.svh"

module rrag_tb;

    localparam int TIMEOUT = 50;

    logic                                   clk;
    logic                                   reset;
    rrag_pkg::uop_t                         uop;
    logic                                   uop_valid;
    rrag_pkg::reg_wb_t [`RRAG_WB_PORTS-1:0] reg_wb;
    rrag_pkg::seg_wb_t [`RRAG_WB_PORTS-1:0] seg_wb;
    logic                                   fwd_stall;
    logic                                   stall;
    logic                                   out_valid;
    rrag_pkg::stage_out_t                   out;

    // Reference copies of what the writebacks have stored
    logic [`RRAG_DATA_W-1:0] gpr_model [`RRAG_NUM_GPR];
    logic [`RRAG_SEL_W-1:0]  sel_model [`RRAG_NUM_SEG];
    logic [`RRAG_TAG_W-1:0]  exp_tag;
    logic [31:0]             lcg_state;
    string                   test_name;

    rrag uut (
        .clk(clk), .reset(reset), .uop(uop), .uop_valid(uop_valid),
        .reg_wb(reg_wb), .seg_wb(seg_wb), .fwd_stall(fwd_stall),
        .stall(stall), .out_valid(out_valid), .out(out)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`RRAG_DATA_W-1:0] size_in_bytes(input rrag_pkg::opsize_e s);
        case (s)
            rrag_pkg::size_byte:  return 32'd1;
            rrag_pkg::size_word:  return 32'd2;
            rrag_pkg::size_dword: return 32'd4;
            default:              return 32'd8;
        endcase
    endfunction

    // Iteration i of n, addresses step upward by the access size
    function automatic rrag_pkg::stage_out_t make_expected(input rrag_pkg::uop_t u,
                                                           input int i, input int n);
        rrag_pkg::stage_out_t    e;
        logic [`RRAG_DATA_W-1:0] step;
        step            = size_in_bytes(u.opsize) * 32'(i);
        e.tag           = exp_tag;
        e.mem_addr1     = (u.use_base ? gpr_model[u.base_addr] : 32'd0)
                        + (u.use_index ? gpr_model[u.index_addr] << u.scale : 32'd0)
                        + u.disp + (32'(sel_model[u.seg1_addr]) << 16) + step;
        e.mem_addr2     = gpr_model[u.str_addr] + (32'(sel_model[u.seg2_addr]) << 16) + step;
        e.mem_addr1_end = e.mem_addr1 + size_in_bytes(u.opsize) - 32'd1;
        e.mem_addr2_end = e.mem_addr2 + size_in_bytes(u.opsize) - 32'd1;
        e.reg1          = gpr_model[u.base_addr];
        e.reg2          = gpr_model[u.index_addr];
        e.reg3          = gpr_model[u.rep_count_addr];
        e.reg4          = gpr_model[u.str_addr];
        e.sel1          = sel_model[u.seg1_addr];
        e.sel2          = sel_model[u.seg2_addr];
        e.lim1          = 20'h0FFFF + 20'(u.seg1_addr) * 20'h10000;
        e.lim2          = 20'h0FFFF + 20'(u.seg2_addr) * 20'h10000;
        e.rep_index     = 32'(i);
        e.rep_last      = u.is_rep && (i == n - 1);
        e.opsize        = u.opsize;
        return e;
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_addr(input string what, input logic [`RRAG_DATA_W-1:0] exp,
                                input logic [`RRAG_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_tag(input logic [`RRAG_TAG_W-1:0] exp,
                               input logic [`RRAG_TAG_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: tag expected %h actual %h", test_name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_out(input rrag_pkg::stage_out_t exp,
                               input rrag_pkg::stage_out_t act);
        compare_tag(exp.tag, act.tag);
        compare_addr("mem_addr1", exp.mem_addr1, act.mem_addr1);
        compare_addr("mem_addr2", exp.mem_addr2, act.mem_addr2);
        compare_addr("mem_addr1_end", exp.mem_addr1_end, act.mem_addr1_end);
        compare_addr("mem_addr2_end", exp.mem_addr2_end, act.mem_addr2_end);
        if (act !== exp) begin
            $display("FAIL %s: out expected %h actual %h", test_name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_handshake(input logic exp_valid, input logic exp_stall);
        if ({out_valid, stall} !== {exp_valid, exp_stall}) begin
            $display("FAIL %s: out_valid,stall expected %b%b actual %b%b", test_name,
                     exp_valid, exp_stall, out_valid, stall);
            abort_run();
        end
    endtask

    task automatic drive_uop(input rrag_pkg::uop_t u);
        uop       = u;
        uop_valid = 1'b1;
    endtask

    task automatic write_gpr(input logic [2:0] addr, input logic [`RRAG_DATA_W-1:0] data,
                             input logic [`RRAG_TAG_W-1:0] tag);
        reg_wb[addr[1:0]] = '{1'b1, addr, data, tag};
        gpr_model[addr]   = data;
        @(negedge clk);
        reg_wb = '0;
    endtask

    task automatic write_sel(input logic [2:0] addr, input logic [`RRAG_SEL_W-1:0] sel,
                             input logic [`RRAG_TAG_W-1:0] tag);
        seg_wb[addr[1:0]] = '{1'b1, addr, sel, tag};
        sel_model[addr]   = sel;
        @(negedge clk);
        seg_wb = '0;
    endtask

    // Starts and ends on a falling edge, the accept edge lies in between
    task automatic expect_output(input rrag_pkg::uop_t u, input int i, input int n);
        int waited;
        waited = 0;
        #1;
        while (out_valid !== 1'b1) begin
            if (waited >= TIMEOUT) begin
                $display("%s: out_valid did not rise in time", test_name);
                abort_run();
            end
            @(negedge clk);
            #1;
            waited++;
        end
        compare_out(make_expected(u, i, n), out);
        compare_handshake(1'b1, u.is_rep && (i != n - 1));
        @(negedge clk);
        exp_tag++;
    endtask

    task automatic test_tags_and_limits();
        rrag_pkg::uop_t u;
        test_name = "tags and limits";
        for (int k = 0; k < `RRAG_NUM_SEG; k++) begin
            u           = '0;
            u.seg1_addr = 3'(k);
            u.seg2_addr = 3'(7 - k);
            u.mem1_use  = 1'b1;
            drive_uop(u);
            expect_output(u, 0, 1);
        end
        uop_valid = 1'b0;
    endtask

    task automatic test_addresses();
        rrag_pkg::uop_t u;
        test_name = "address calculation";
        for (int r = 0; r < `RRAG_NUM_GPR; r++) begin
            write_gpr(3'(r), next_rand(), '0);
            write_sel(3'(r), 16'(next_rand()), '0);
        end
        for (int c = 0; c < 64; c++) begin
            u            = '0;
            u.base_addr  = 3'(next_rand() >> 29);
            u.index_addr = 3'(next_rand() >> 29);
            u.str_addr   = 3'(next_rand() >> 29);
            u.seg1_addr  = 3'(next_rand() >> 29);
            u.seg2_addr  = 3'(next_rand() >> 29);
            u.disp       = next_rand();
            u.use_base   = c[5];
            u.use_index  = c[4];
            u.scale      = c[3:2];
            u.opsize     = rrag_pkg::opsize_e'(c[1:0]);
            u.mem1_use   = 1'b1;
            u.mem2_use   = 1'b1;
            drive_uop(u);
            #1;
            compare_handshake(1'b1, 1'b0);
            expect_output(u, 0, 1);
        end
        uop_valid = 1'b0;
    endtask

    task automatic test_pending(input bit on_seg);
        rrag_pkg::uop_t         writer;
        rrag_pkg::uop_t         reader;
        logic [`RRAG_TAG_W-1:0] writer_tag;
        test_name = on_seg ? "segment pending" : "register pending";
        writer    = '0;
        reader    = '0;
        if (on_seg) begin
            writer.seg_dest  = 8'h20;
            reader.mem1_use  = 1'b1;
            reader.seg1_addr = 3'd5;
        end else begin
            writer.gpr_dest  = 8'h08;
            reader.use_base  = 1'b1;
            reader.base_addr = 3'd3;
        end
        reader.disp = next_rand();
        writer_tag  = exp_tag;
        drive_uop(writer);
        expect_output(writer, 0, 1);
        drive_uop(reader);
        #1;
        compare_handshake(1'b0, 1'b1);
        @(negedge clk);
        // Stale writer tag updates data but keeps the hazard
        if (on_seg) begin
            write_sel(3'd5, 16'(next_rand()), writer_tag + 1'b1);
        end else begin
            write_gpr(3'd3, next_rand(), writer_tag + 1'b1);
        end
        #1;
        compare_handshake(1'b0, 1'b1);
        @(negedge clk);
        if (on_seg) begin
            write_sel(3'd5, 16'(next_rand()), writer_tag);
        end else begin
            write_gpr(3'd3, next_rand(), writer_tag);
        end
        expect_output(reader, 0, 1);
        uop_valid = 1'b0;
    endtask

    task automatic test_back_pressure();
        rrag_pkg::uop_t u;
        test_name  = "back-pressure";
        u          = '0;
        u.use_base = 1'b1;
        u.mem1_use = 1'b1;
        u.mem2_use = 1'b1;
        u.disp     = next_rand();
        u.opsize   = rrag_pkg::size_dword;
        fwd_stall  = 1'b1;
        drive_uop(u);
        repeat (3) begin
            #1;
            compare_handshake(1'b0, 1'b1);
            @(negedge clk);
        end
        fwd_stall = 1'b0;
        expect_output(u, 0, 1);
        uop_valid = 1'b0;
    endtask

    task automatic test_rep(input logic [31:0] count, input rrag_pkg::opsize_e size,
                            input bit pause);
        rrag_pkg::uop_t u;
        int             n;
        test_name = pause ? "rep with back-pressure" : "rep expansion";
        write_gpr(3'd6, count, '0);
        write_gpr(3'd7, next_rand(), '0);
        n                = (count == 32'd0) ? 1 : int'(count);
        u                = '0;
        u.is_rep         = 1'b1;
        u.rep_count_addr = 3'd6;
        u.str_addr       = 3'd7;
        u.base_addr      = 3'd2;
        u.use_base       = 1'b1;
        u.mem1_use       = 1'b1;
        u.mem2_use       = 1'b1;
        u.seg1_addr      = 3'd1;
        u.seg2_addr      = 3'd2;
        u.opsize         = size;
        u.disp           = next_rand();
        drive_uop(u);
        for (int i = 0; i < n; i++) begin
            if (pause && i == 2) begin
                fwd_stall = 1'b1;
                repeat (2) begin
                    #1;
                    compare_handshake(1'b0, 1'b1);
                    @(negedge clk);
                end
                fwd_stall = 1'b0;
            end
            expect_output(u, i, n);
        end
        uop_valid = 1'b0;
        #1;
        compare_handshake(1'b0, 1'b0);
        @(negedge clk);
    endtask

    initial begin
        lcg_state = 32'h131f945b;
        clk       = 1'b0;
        reset     = 1'b1;
        uop       = '0;
        uop_valid = 1'b0;
        reg_wb    = '0;
        seg_wb    = '0;
        fwd_stall = 1'b0;
        exp_tag   = '0;
        test_name = "reset";
        for (int r = 0; r < `RRAG_NUM_GPR; r++) begin
            gpr_model[r] = '0;
            sel_model[r] = '0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        #1;
        compare_handshake(1'b0, 1'b0);
        @(negedge clk);
        test_tags_and_limits();
        test_addresses();
        test_pending(1'b0);
        test_pending(1'b1);
        test_back_pressure();
        test_rep(32'd0, rrag_pkg::size_word, 1'b0);
        test_rep(32'd1, rrag_pkg::size_byte, 1'b0);
        test_rep(32'd5, rrag_pkg::size_dword, 1'b0);
        test_rep(32'd5, rrag_pkg::size_qword, 1'b1);
        $display("Finished with no errors");
        $finish;
    end

endmodule
